// File: hw/umi_tl_pkg.sv
`default_nettype none

package umi_tl_pkg;

    // Widths
    localparam int cw      = 32;
    localparam int aw      = 64;
    localparam int dw      = 64;
    localparam int tl_aw   = 56;
    localparam int src_w   = 4;
    localparam int num_src = 1 << src_w;
    localparam int mask_w  = 8;

    // UMI command fields
    localparam int opcode_lsb = 0;
    localparam int opcode_msb = 4;
    localparam int size_lsb   = 5;
    localparam int size_msb   = 7;
    localparam int len_lsb    = 8;
    localparam int len_msb    = 15;
    localparam int err_lsb    = 24;
    localparam int err_msb    = 25;

    // UMI error codes
    localparam logic [1:0] umi_err_ok  = 2'd0;
    localparam logic [1:0] umi_err_slv = 2'd2;

    typedef enum logic [4:0] {
        req_read   = 5'd1,
        resp_read  = 5'd2,
        req_write  = 5'd3,
        resp_write = 5'd4,
        req_posted = 5'd5
    } umi_opcode_e;

    typedef enum logic [2:0] {
        put_full    = 3'd0,
        put_partial = 3'd1,
        get         = 3'd4
    } tl_a_opcode_e;

    typedef enum logic [2:0] {
        access_ack      = 3'd0,
        access_ack_data = 3'd1
    } tl_d_opcode_e;

    typedef struct packed {
        logic [cw-1:0] cmd;
        logic [aw-1:0] dstaddr;
        logic [aw-1:0] srcaddr;
        logic [dw-1:0] data;
    } umi_req_t;

    typedef struct packed {
        logic [cw-1:0] cmd;
        logic [aw-1:0] dstaddr;
        logic [aw-1:0] srcaddr;
        logic [dw-1:0] data;
    } umi_resp_t;

    typedef struct packed {
        tl_a_opcode_e        opcode;
        logic [2:0]          param;
        logic [2:0]          size;
        logic [src_w-1:0]    source;
        logic [tl_aw-1:0]    address;
        logic [mask_w-1:0]   mask;
        logic [dw-1:0]       data;
        logic                corrupt;
    } tl_a_t;

    typedef struct packed {
        tl_d_opcode_e        opcode;
        logic [1:0]          param;
        logic [2:0]          size;
        logic [src_w-1:0]    source;
        logic                sink;
        logic                denied;
        logic [dw-1:0]       data;
        logic                corrupt;
    } tl_d_t;

    // Per source ID state kept while a request is outstanding
    typedef struct packed {
        logic                posted;
        logic                is_read;
        logic [2:0]          byte_off;
        logic [2:0]          size;
        logic [aw-1:0]       dstaddr;
        logic [aw-1:0]       srcaddr;
    } src_entry_t;

endpackage

`default_nettype wire

// File: hw/tl_source_table.sv
`default_nettype none

module tl_source_table (
    input  wire logic                       clk,
    input  wire logic                       arst_n,

    output logic                            table_free,
    output logic [umi_tl_pkg::src_w-1:0]    alloc_id,

    input  wire logic                       alloc_valid,
    input  wire umi_tl_pkg::src_entry_t     alloc_entry,

    input  wire logic                       free_valid,
    input  wire logic [umi_tl_pkg::src_w-1:0] free_id,

    output umi_tl_pkg::src_entry_t          lookup_entry
);

    import umi_tl_pkg::*;

    logic [num_src-1:0] busy;
    logic [num_src-1:0] busy_next;
    logic               next_free;
    logic [src_w-1:0]   next_id;

    logic               offer_ok;
    logic [src_w-1:0]   offer_id;

    src_entry_t         entries [num_src];

    // Busy state after this cycle's allocate and free
    always_comb begin
        busy_next = busy;
        if (free_valid) begin
            busy_next[free_id] = 1'b0;
        end
        if (alloc_valid) begin
            busy_next[alloc_id] = 1'b1;
        end
    end

    // Lowest free ID wins
    always_comb begin
        next_free = 1'b0;
        next_id   = '0;
        for (int i = num_src - 1; i >= 0; i--) begin
            if (!busy_next[i]) begin
                next_free = 1'b1;
                next_id   = src_w'(i);
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy <= '0;
        end else begin
            busy <= busy_next;
        end
    end

    // Offered ID only moves once it is taken or while the table is full,
    // so a stalled A beat keeps its source
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            offer_ok <= 1'b1;
            offer_id <= '0;
        end else if (alloc_valid || !offer_ok) begin
            offer_ok <= next_free;
            offer_id <= next_id;
        end
    end

    always_ff @(posedge clk) begin
        if (alloc_valid) begin
            entries[alloc_id] <= alloc_entry;
        end
    end

    assign table_free   = offer_ok;
    assign alloc_id     = offer_id;

    // Read in the same cycle as the D beat
    assign lookup_entry = entries[free_id];

endmodule

`default_nettype wire

// File: hw/umi_req_to_tl_a.sv
`default_nettype none

module umi_req_to_tl_a (
    input  wire umi_tl_pkg::umi_req_t           umi_req,
    input  wire logic                           umi_req_valid,
    output logic                                umi_req_ready,

    output umi_tl_pkg::tl_a_t                   tl_a,
    output logic                                tl_a_valid,
    input  wire logic                           tl_a_ready,

    input  wire logic                           table_free,
    input  wire logic [umi_tl_pkg::src_w-1:0]   alloc_id,
    output logic                                alloc_valid,
    output umi_tl_pkg::src_entry_t              alloc_entry
);

    import umi_tl_pkg::*;

    umi_opcode_e        req_op;
    logic [2:0]         req_size;
    logic [2:0]         byte_off;
    logic               is_read;
    logic               is_posted;
    logic [mask_w-1:0]  base_mask;

    // Command decode
    always_comb begin
        req_op    = umi_opcode_e'(umi_req.cmd[opcode_msb:opcode_lsb]);
        req_size  = umi_req.cmd[size_msb:size_lsb];
        byte_off  = umi_req.dstaddr[2:0];
        is_read   = (req_op == req_read);
        is_posted = (req_op == req_posted);
    end

    // 2**size bytes starting at lane 0
    always_comb begin
        case (req_size)
            3'd0:    base_mask = 8'h01;
            3'd1:    base_mask = 8'h03;
            3'd2:    base_mask = 8'h0f;
            default: base_mask = 8'hff;
        endcase
    end

    always_comb begin
        tl_a         = '0;
        tl_a.param   = 3'd0;
        tl_a.corrupt = 1'b0;
        tl_a.size    = req_size;
        tl_a.source  = alloc_id;
        tl_a.address = umi_req.dstaddr[tl_aw-1:0];
        tl_a.mask    = base_mask << byte_off;
        if (is_read) begin
            tl_a.opcode = get;
            tl_a.data   = '0;
        end else begin
            tl_a.opcode = (req_size == 3'd3) ? put_full : put_partial;
            // Move write bytes onto their lanes
            tl_a.data   = umi_req.data << {byte_off, 3'b000};
        end
    end

    always_comb begin
        alloc_entry          = '0;
        alloc_entry.posted   = is_posted;
        alloc_entry.is_read  = is_read;
        alloc_entry.byte_off = byte_off;
        alloc_entry.size     = req_size;
        alloc_entry.dstaddr  = umi_req.dstaddr;
        alloc_entry.srcaddr  = umi_req.srcaddr;
    end

    // Pass-through handshake held off when no ID is free
    assign tl_a_valid    = umi_req_valid & table_free;
    assign umi_req_ready = tl_a_ready & table_free;
    assign alloc_valid   = tl_a_valid & tl_a_ready;

endmodule

`default_nettype wire

// File: hw/tl_d_to_umi_resp.sv
`default_nettype none

module tl_d_to_umi_resp (
    input  wire logic                           clk,
    input  wire logic                           arst_n,

    input  wire umi_tl_pkg::tl_d_t              tl_d,
    input  wire logic                           tl_d_valid,
    output logic                                tl_d_ready,

    output logic                                free_valid,
    output logic [umi_tl_pkg::src_w-1:0]        free_id,
    input  wire umi_tl_pkg::src_entry_t         lookup_entry,

    output umi_tl_pkg::umi_resp_t               umi_resp,
    output logic                                umi_resp_valid,
    input  wire logic                           umi_resp_ready
);

    import umi_tl_pkg::*;

    logic           d_fire;
    logic           load;
    logic [dw-1:0]  shifted;
    logic [dw-1:0]  keep;
    umi_resp_t      resp_d;
    umi_resp_t      resp_q;
    logic           resp_valid_q;

    assign tl_d_ready = !resp_valid_q || umi_resp_ready;
    assign d_fire     = tl_d_valid && tl_d_ready;
    assign free_valid = d_fire;
    assign free_id    = tl_d.source;

    // Acks for posted writes free the ID and go no further
    assign load       = d_fire && !lookup_entry.posted;

    always_comb begin
        shifted = tl_d.data >> {lookup_entry.byte_off, 3'b000};
        case (lookup_entry.size)
            3'd0:    keep = 64'h0000_0000_0000_00ff;
            3'd1:    keep = 64'h0000_0000_0000_ffff;
            3'd2:    keep = 64'h0000_0000_ffff_ffff;
            default: keep = '1;
        endcase
    end

    always_comb begin
        resp_d = '0;
        resp_d.cmd[opcode_msb:opcode_lsb] = lookup_entry.is_read ? resp_read : resp_write;
        resp_d.cmd[size_msb:size_lsb]     = lookup_entry.size;
        resp_d.cmd[err_msb:err_lsb]       = (tl_d.denied || tl_d.corrupt) ?
                                            umi_err_slv : umi_err_ok;
        // Response goes back to the requester
        resp_d.dstaddr = lookup_entry.srcaddr;
        resp_d.srcaddr = lookup_entry.dstaddr;
        resp_d.data    = lookup_entry.is_read ? (shifted & keep) : '0;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            resp_valid_q <= 1'b0;
        end else if (load) begin
            resp_valid_q <= 1'b1;
        end else if (umi_resp_ready) begin
            resp_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            resp_q <= resp_d;
        end
    end

    assign umi_resp       = resp_q;
    assign umi_resp_valid = resp_valid_q;

endmodule

`default_nettype wire

// File: hw/umi2tl_np.sv
`default_nettype none

module umi2tl_np (
    input  wire logic                   clk,
    input  wire logic                   arst_n,

    // UMI device side
    input  wire umi_tl_pkg::umi_req_t   umi_req,
    input  wire logic                   umi_req_valid,
    output logic                        umi_req_ready,

    output umi_tl_pkg::umi_resp_t       umi_resp,
    output logic                        umi_resp_valid,
    input  wire logic                   umi_resp_ready,

    // TileLink master side
    output umi_tl_pkg::tl_a_t           tl_a,
    output logic                        tl_a_valid,
    input  wire logic                   tl_a_ready,

    input  wire umi_tl_pkg::tl_d_t      tl_d,
    input  wire logic                   tl_d_valid,
    output logic                        tl_d_ready
);

    import umi_tl_pkg::*;

    logic               table_free;
    logic [src_w-1:0]   alloc_id;
    logic               alloc_valid;
    src_entry_t         alloc_entry;
    logic               free_valid;
    logic [src_w-1:0]   free_id;
    src_entry_t         lookup_entry;

    tl_source_table u_table (
        .clk            (clk),
        .arst_n         (arst_n),
        .table_free     (table_free),
        .alloc_id       (alloc_id),
        .alloc_valid    (alloc_valid),
        .alloc_entry    (alloc_entry),
        .free_valid     (free_valid),
        .free_id        (free_id),
        .lookup_entry   (lookup_entry)
    );

    umi_req_to_tl_a u_req (
        .umi_req        (umi_req),
        .umi_req_valid  (umi_req_valid),
        .umi_req_ready  (umi_req_ready),
        .tl_a           (tl_a),
        .tl_a_valid     (tl_a_valid),
        .tl_a_ready     (tl_a_ready),
        .table_free     (table_free),
        .alloc_id       (alloc_id),
        .alloc_valid    (alloc_valid),
        .alloc_entry    (alloc_entry)
    );

    tl_d_to_umi_resp u_resp (
        .clk            (clk),
        .arst_n         (arst_n),
        .tl_d           (tl_d),
        .tl_d_valid     (tl_d_valid),
        .tl_d_ready     (tl_d_ready),
        .free_valid     (free_valid),
        .free_id        (free_id),
        .lookup_entry   (lookup_entry),
        .umi_resp       (umi_resp),
        .umi_resp_valid (umi_resp_valid),
        .umi_resp_ready (umi_resp_ready)
    );

endmodule

`default_nettype wire

// File: sim/tl_mem_model.sv
`default_nettype none

module tl_mem_model (
    input  wire logic                   clk,
    input  wire logic                   arst_n,
    input  wire logic                   hold,

    input  wire umi_tl_pkg::tl_a_t      tl_a,
    input  wire logic                   tl_a_valid,
    output logic                        tl_a_ready,

    output umi_tl_pkg::tl_d_t           tl_d,
    output logic                        tl_d_valid,
    input  wire logic                   tl_d_ready
);

    import umi_tl_pkg::*;

    logic [dw-1:0]      mem [32];
    logic [num_src-1:0] pend_v;
    logic [2:0]         pend_wait [num_src];
    tl_d_t              pend_beat [num_src];

    logic               pick_ok;
    logic [src_w-1:0]   pick_id;
    logic               issue;
    tl_d_t              beat;
    logic [4:0]         widx;

    // Lowest source whose delay has run out
    always_comb begin
        pick_ok = 1'b0;
        pick_id = '0;
        for (int i = num_src - 1; i >= 0; i--) begin
            if (pend_v[i] && pend_wait[i] == 3'd0) begin
                pick_ok = 1'b1;
                pick_id = src_w'(i);
            end
        end
    end

    assign issue = pick_ok && !hold && (!tl_d_valid || tl_d_ready);

    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pend_v     <= '0;
            tl_d       <= '0;
            tl_d_valid <= 1'b0;
            tl_a_ready <= 1'b1;
            for (int w = 0; w < 32; w++) begin
                for (int b = 0; b < 8; b++) begin
                    mem[w][8*b +: 8] <= 8'(w * 8 + b) ^ 8'h5a;
                end
            end
        end else begin
            tl_a_ready <= ($urandom_range(7, 0) != 0);
            for (int i = 0; i < num_src; i++) begin
                if (pend_v[i] && pend_wait[i] != 3'd0) begin
                    pend_wait[i] <= pend_wait[i] - 3'd1;
                end
            end
            if (issue) begin
                tl_d            <= pend_beat[pick_id];
                tl_d_valid      <= 1'b1;
                pend_v[pick_id] <= 1'b0;
            end else if (tl_d_valid && tl_d_ready) begin
                tl_d_valid <= 1'b0;
            end
            // Memory access happens on A acceptance and the answer waits in its slot
            if (tl_a_valid && tl_a_ready) begin
                widx        = tl_a.address[7:3];
                beat        = '0;
                beat.source = tl_a.source;
                beat.size   = tl_a.size;
                beat.denied = tl_a.address[40];
                if (tl_a.opcode == get) begin
                    beat.opcode = access_ack_data;
                    if (!beat.denied) begin
                        beat.data = mem[widx];
                    end
                end else begin
                    beat.opcode = access_ack;
                    for (int b = 0; b < 8; b++) begin
                        if (!beat.denied && tl_a.mask[b]) begin
                            mem[widx][8*b +: 8] <= tl_a.data[8*b +: 8];
                        end
                    end
                end
                pend_v[tl_a.source]    <= 1'b1;
                pend_wait[tl_a.source] <= 3'($urandom_range(4, 0));
                pend_beat[tl_a.source] <= beat;
            end
        end
    end

endmodule

`default_nettype wire

// File: sim/umi2tl_chk.sv
`default_nettype none

module umi2tl_chk (
    input  wire logic                   clk,
    input  wire logic                   arst_n,
    input  wire umi_tl_pkg::tl_a_t      tl_a,
    input  wire logic                   tl_a_valid,
    input  wire logic                   tl_a_ready,
    input  wire umi_tl_pkg::tl_d_t      tl_d,
    input  wire logic                   tl_d_valid,
    input  wire logic                   tl_d_ready,
    input  wire umi_tl_pkg::umi_resp_t  umi_resp,
    input  wire logic                   umi_resp_valid,
    input  wire logic                   umi_resp_ready
);

    import umi_tl_pkg::*;

    logic [num_src-1:0] busy;
    logic [num_src-1:0] set_mask;
    logic [num_src-1:0] clr_mask;
    int                 fail_count = 0;

    // Outstanding IDs as seen on the bus
    assign set_mask = (tl_a_valid && tl_a_ready) ? (num_src'(1) << tl_a.source) : '0;
    assign clr_mask = (tl_d_valid && tl_d_ready) ? (num_src'(1) << tl_d.source) : '0;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy <= '0;
        end else begin
            busy <= (busy | set_mask) & ~clr_mask;
        end
    end

    a_stable: assert property (@(posedge clk) disable iff (!arst_n)
        tl_a_valid && !tl_a_ready |=> tl_a_valid && $stable(tl_a))
        else begin
            $error("A beat changed while stalled");
            fail_count++;
        end

    resp_stable: assert property (@(posedge clk) disable iff (!arst_n)
        umi_resp_valid && !umi_resp_ready |=> umi_resp_valid && $stable(umi_resp))
        else begin
            $error("UMI response changed while stalled");
            fail_count++;
        end

    not_full: assert property (@(posedge clk) disable iff (!arst_n)
        tl_a_valid |-> !(&busy))
        else begin
            $error("A beat offered with all IDs busy");
            fail_count++;
        end

    fresh_id: assert property (@(posedge clk) disable iff (!arst_n)
        tl_a_valid |-> !busy[tl_a.source])
        else begin
            $error("A beat reuses an outstanding ID");
            fail_count++;
        end

    known_id: assert property (@(posedge clk) disable iff (!arst_n)
        tl_d_valid |-> busy[tl_d.source])
        else begin
            $error("D beat for an ID not outstanding");
            fail_count++;
        end

endmodule

bind umi2tl_np umi2tl_chk u_chk (
    .clk            (clk),
    .arst_n         (arst_n),
    .tl_a           (tl_a),
    .tl_a_valid     (tl_a_valid),
    .tl_a_ready     (tl_a_ready),
    .tl_d           (tl_d),
    .tl_d_valid     (tl_d_valid),
    .tl_d_ready     (tl_d_ready),
    .umi_resp       (umi_resp),
    .umi_resp_valid (umi_resp_valid),
    .umi_resp_ready (umi_resp_ready)
);

`default_nettype wire

// File: sim/tb_umi2tl.sv
`default_nettype none

module tb_umi2tl;

    import umi_tl_pkg::*;

    localparam int          num_entries = 24;
    localparam int          burst_len   = 20;
    localparam int          max_cycles  = num_entries * 60;
    localparam logic [63:0] deny_bit    = 64'h0000_0100_0000_0000;

    logic       clk;
    logic       arst_n;
    logic       hold;
    umi_req_t   umi_req;
    logic       umi_req_valid;
    logic       umi_req_ready;
    umi_resp_t  umi_resp;
    logic       umi_resp_valid;
    logic       umi_resp_ready;
    tl_a_t      tl_a;
    logic       tl_a_valid;
    logic       tl_a_ready;
    tl_d_t      tl_d;
    logic       tl_d_valid;
    logic       tl_d_ready;

    string          t_name [num_entries];
    umi_opcode_e    t_op   [num_entries];
    logic [63:0]    t_addr [num_entries];
    logic [2:0]     t_size [num_entries];
    logic [63:0]    t_data [num_entries];

    // Owed responses found again by their dstaddr
    string          exp_name [64];
    umi_resp_t      exp_resp [64];
    logic           exp_rd   [64];
    logic           exp_done [64];
    int             n_exp = 0;

    logic [7:0]     shadow [256];
    int             errors = 0;
    int             checks = 0;
    int             resp_count = 0;
    int             cycles = 0;

    umi2tl_np dut (
        .clk (clk), .arst_n (arst_n),
        .umi_req (umi_req), .umi_req_valid (umi_req_valid), .umi_req_ready (umi_req_ready),
        .umi_resp (umi_resp), .umi_resp_valid (umi_resp_valid),
        .umi_resp_ready (umi_resp_ready),
        .tl_a (tl_a), .tl_a_valid (tl_a_valid), .tl_a_ready (tl_a_ready),
        .tl_d (tl_d), .tl_d_valid (tl_d_valid), .tl_d_ready (tl_d_ready)
    );

    tl_mem_model u_mem (
        .clk (clk), .arst_n (arst_n), .hold (hold),
        .tl_a (tl_a), .tl_a_valid (tl_a_valid), .tl_a_ready (tl_a_ready),
        .tl_d (tl_d), .tl_d_valid (tl_d_valid), .tl_d_ready (tl_d_ready)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= max_cycles) begin
            $display("timeout after %0d cycles, %0d of %0d responses seen",
                     cycles, resp_count, n_exp);
            $display("=== FAIL ===");
            $finish;
        end
    end

    always @(negedge clk) begin
        if (arst_n) begin
            umi_resp_ready = ($urandom_range(3, 0) != 0);
        end
    end

    always @(posedge clk) begin
        if (arst_n && umi_resp_valid && umi_resp_ready) begin
            take_response(umi_resp);
        end
    end

    task automatic compare(input string name, input logic [63:0] expected,
                           input logic [63:0] actual);
        checks++;
        if (expected !== actual) begin
            $display("mismatch %s: expected %h, actual %h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic set_entry(input int i, input string name, input umi_opcode_e op,
                             input logic [63:0] addr, input logic [2:0] size,
                             input logic [63:0] data);
        t_name[i] = name;
        t_op[i]   = op;
        t_addr[i] = addr;
        t_size[i] = size;
        t_data[i] = data;
    endtask

    // Expected response from the shadow in request order
    task automatic record_request(input string name, input umi_req_t req);
        umi_opcode_e    op;
        logic [2:0]     size;
        logic           denied;
        umi_resp_t      r;
        op     = umi_opcode_e'(req.cmd[opcode_msb:opcode_lsb]);
        size   = req.cmd[size_msb:size_lsb];
        denied = req.dstaddr[40];
        r      = '0;
        for (int b = 0; b < (1 << size); b++) begin
            if (op == req_read) begin
                r.data[8*b +: 8] = shadow[8'(req.dstaddr[7:0] + b)];
            end else if (!denied) begin
                shadow[8'(req.dstaddr[7:0] + b)] = req.data[8*b +: 8];
            end
        end
        if (op != req_posted) begin
            r.cmd[opcode_msb:opcode_lsb] = (op == req_read) ? resp_read : resp_write;
            r.cmd[size_msb:size_lsb]     = size;
            r.cmd[err_msb:err_lsb]       = denied ? 2'd2 : 2'd0;
            r.dstaddr                    = req.srcaddr;
            r.srcaddr                    = req.dstaddr;
            exp_name[n_exp] = name;
            exp_resp[n_exp] = r;
            exp_rd[n_exp]   = (op == req_read) && !denied;
            exp_done[n_exp] = 1'b0;
            n_exp++;
        end
    endtask

    task automatic send_req(input string name, input umi_opcode_e op,
                            input logic [63:0] addr, input logic [2:0] size,
                            input logic [63:0] data, input logic [63:0] src);
        umi_req_t req;
        req = '0;
        req.cmd[opcode_msb:opcode_lsb] = op;
        req.cmd[size_msb:size_lsb]     = size;
        req.dstaddr = addr;
        req.srcaddr = src;
        req.data    = data;
        @(negedge clk);
        umi_req       = req;
        umi_req_valid = 1'b1;
        @(posedge clk);
        while (!umi_req_ready) @(posedge clk);
        record_request(name, req);
    endtask

    task automatic take_response(input umi_resp_t r);
        int hit;
        hit = -1;
        for (int i = 0; i < n_exp; i++) begin
            if (!exp_done[i] && exp_resp[i].dstaddr == r.dstaddr) hit = i;
        end
        resp_count++;
        if (hit < 0) begin
            $display("unexpected response with dstaddr %h", r.dstaddr);
            errors++;
        end else begin
            exp_done[hit] = 1'b1;
            compare({exp_name[hit], " cmd"}, exp_resp[hit].cmd, r.cmd);
            compare({exp_name[hit], " srcaddr"}, exp_resp[hit].srcaddr, r.srcaddr);
            if (exp_rd[hit]) compare({exp_name[hit], " data"}, exp_resp[hit].data, r.data);
        end
    endtask

    initial begin
        int seed;
        seed = $urandom(32'hf3ab);
        arst_n = 1'b0;
        hold = 1'b0;
        umi_req = '0;
        umi_req_valid = 1'b0;
        umi_resp_ready = 1'b0;
        for (int a = 0; a < 256; a++) shadow[a] = 8'(a) ^ 8'h5a;

        set_entry(0,  "wr_b0",     req_write,  64'h08, 3'd0, 64'ha1);
        set_entry(1,  "rd_b0",     req_read,   64'h08, 3'd0, 64'h0);
        set_entry(2,  "wr_b5",     req_write,  64'h0d, 3'd0, 64'h3c);
        set_entry(3,  "rd_b5",     req_read,   64'h0d, 3'd0, 64'h0);
        set_entry(4,  "wr_h2",     req_write,  64'h12, 3'd1, 64'hbeef);
        set_entry(5,  "rd_h2",     req_read,   64'h12, 3'd1, 64'h0);
        set_entry(6,  "wr_h6",     req_write,  64'h1e, 3'd1, 64'h1234);
        set_entry(7,  "rd_h6",     req_read,   64'h1e, 3'd1, 64'h0);
        set_entry(8,  "wr_w4",     req_write,  64'h24, 3'd2, 64'hcafe_f00d);
        set_entry(9,  "rd_w4",     req_read,   64'h24, 3'd2, 64'h0);
        set_entry(10, "wr_d0",     req_write,  64'h30, 3'd3, 64'h0123_4567_89ab_cdef);
        set_entry(11, "wr_merge",  req_write,  64'h33, 3'd0, 64'h77);
        set_entry(12, "rd_merge",  req_read,   64'h30, 3'd3, 64'h0);
        set_entry(13, "pw_w0",     req_posted, 64'h40, 3'd2, 64'hdead_beef);
        set_entry(14, "pw_b7",     req_posted, 64'h47, 3'd0, 64'h99);
        set_entry(15, "rd_posted", req_read,   64'h40, 3'd3, 64'h0);
        set_entry(16, "wr_deny",   req_write,  deny_bit | 64'h50, 3'd3, '1);
        set_entry(17, "rd_deny",   req_read,   deny_bit | 64'h50, 3'd3, 64'h0);
        set_entry(18, "rd_nodeny", req_read,   64'h50, 3'd3, 64'h0);
        set_entry(19, "pw_deny",   req_posted, deny_bit | 64'h58, 3'd1, 64'h6666);
        set_entry(20, "rd_58",     req_read,   64'h58, 3'd3, 64'h0);
        set_entry(21, "wr_w0",     req_write,  64'h60, 3'd2, 64'h5555_aaaa);
        set_entry(22, "rd_b2",     req_read,   64'h62, 3'd0, 64'h0);
        set_entry(23, "rd_full",   req_read,   64'h08, 3'd3, 64'h0);

        repeat (4) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        for (int i = 0; i < num_entries; i++) begin
            send_req(t_name[i], t_op[i], t_addr[i], t_size[i], t_data[i],
                     64'h1000 + 64'(i) * 16);
        end
        @(negedge clk);
        umi_req_valid = 1'b0;

        // Read burst while the memory holds back every answer
        hold = 1'b1;
        fork
            begin
                repeat (30) @(negedge clk);
                hold = 1'b0;
            end
            for (int k = 0; k < burst_len; k++) begin
                send_req($sformatf("burst_%0d", k), req_read, 64'(k) * 8, 3'd3, '0,
                         64'h8000 + 64'(k) * 16);
            end
        join
        @(negedge clk);
        umi_req_valid = 1'b0;

        while (resp_count < n_exp) @(posedge clk);
        repeat (20) @(posedge clk);
        for (int i = 0; i < n_exp; i++) begin
            if (!exp_done[i]) begin
                $display("no response arrived for %s", exp_name[i]);
                errors++;
            end
        end
        compare("response count", n_exp, resp_count);
        compare("assertion failures", 0, dut.u_chk.fail_count);
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: list.f
hw/umi_tl_pkg.sv
hw/tl_source_table.sv
hw/umi_req_to_tl_a.sv
hw/tl_d_to_umi_resp.sv
hw/umi2tl_np.sv
sim/tl_mem_model.sv
sim/umi2tl_chk.sv
sim/tb_umi2tl.sv
